/* pss_detector_top.f */
+incdir+.
pss_pkg.sv
pss_sample_intake.sv
pss_correlator_lane.sv
pss_decision.sv
pss_detector_top.sv
pss_detector_tb.sv

/* Makefile */
# Verilator simulation of the PSS detector

VERILATOR ?= verilator
TOP       ?= pss_detector_tb
FILELIST  ?= pss_detector_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* pss_detector_tb.sv */
`timescale 1ns/1ps
`include "pss_macros.svh"

module pss_detector_tb;

    import pss_pkg::*;

    // --------------------
    // stimulus table
    // --------------------

    typedef struct packed {
        pss_mode_e               mode;
        logic [1:0]              req_nid;
        logic [1:0]              kind;
        logic [7:0]              amp;
        logic [7:0]              count;
        logic [1:0]              exp_nid;
        logic [`PSS_SCORE_W-1:0] exp_score;
    } stim_entry_t;

    // kind 0..2 embeds that lane's sequence
    localparam logic [1:0] KIND_NOISE  = 2'd3;
    localparam int         NUM_ENTRIES = 13;
    localparam int         ACK_WAIT    = 20;

    // mode, requested nid, kind, amplitude, samples, final nid, final score
    localparam stim_entry_t STIM_TABLE [NUM_ENTRIES] = '{
        '{MODE_SEARCH, 2'd0, KIND_NOISE, 8'd6,   8'd16, 2'd0, 13'd0},
        '{MODE_SEARCH, 2'd0, 2'd0,       8'd100, 8'd16, 2'd0, 13'd1600},
        '{MODE_SEARCH, 2'd0, KIND_NOISE, 8'd6,   8'd16, 2'd0, 13'd1600},
        '{MODE_SEARCH, 2'd0, 2'd1,       8'd100, 8'd16, 2'd1, 13'd1600},
        '{MODE_SEARCH, 2'd0, KIND_NOISE, 8'd6,   8'd16, 2'd1, 13'd1600},
        '{MODE_SEARCH, 2'd0, 2'd2,       8'd100, 8'd16, 2'd2, 13'd1600},
        '{MODE_SEARCH, 2'd0, KIND_NOISE, 8'd6,   8'd32, 2'd2, 13'd1600},
        '{MODE_FIND,   2'd1, 2'd1,       8'd100, 8'd16, 2'd1, 13'd1600},
        '{MODE_FIND,   2'd1, KIND_NOISE, 8'd6,   8'd16, 2'd1, 13'd1600},
        '{MODE_FIND,   2'd2, 2'd1,       8'd100, 8'd16, 2'd1, 13'd1600},
        '{MODE_SEARCH, 2'd0, KIND_NOISE, 8'd6,   8'd16, 2'd1, 13'd1600},
        // 15 paused samples would line up a lane 0 hit on the next accepted one
        '{MODE_PAUSE,  2'd0, 2'd0,       8'd100, 8'd15, 2'd1, 13'd1600},
        '{MODE_SEARCH, 2'd0, 2'd2,       8'd90,  8'd16, 2'd2, 13'd1440}
    };

    logic                    clk_i = 1'b0;
    logic                    reset_ni;
    logic                    req_i;
    iq_sample_t              sample_i;
    logic                    ack_o;
    pss_mode_e               mode_i;
    logic [1:0]              requested_nid_i;
    logic [1:0]              nid_o;
    logic                    nid_valid_o;
    logic [`PSS_SCORE_W-1:0] peak_score_o;

    // reference window with index 0 as the newest sample
    int         win_re [`PSS_WIN_LEN];
    int         win_im [`PSS_WIN_LEN];
    logic [1:0] model_nid;
    int         model_score;
    logic       lane_hit_seen;

    always #4 clk_i = ~clk_i;

    pss_detector_top i_pss_detector_top (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .req_i           (req_i),
        .sample_i        (sample_i),
        .ack_o           (ack_o),
        .mode_i          (mode_i),
        .requested_nid_i (requested_nid_i),
        .nid_o           (nid_o),
        .nid_valid_o     (nid_valid_o),
        .peak_score_o    (peak_score_o)
    );

    // --------------------
    // helpers
    // --------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [`PSS_WIN_LEN-1:0] lane_seq(input int lane);
        case (lane)
            0:       return `PSS_SEQ_0;
            1:       return `PSS_SEQ_1;
            default: return `PSS_SEQ_2;
        endcase
    endfunction

    function automatic logic signed [`PSS_SAMPLE_W-1:0] noise_value(input int amp);
        int r;
        r = int'($urandom % (2 * amp + 1)) - amp;
        return `PSS_SAMPLE_W'(r);
    endfunction

    function automatic int total_samples();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            total += int'(STIM_TABLE[i].count);
        end
        return total;
    endfunction

    // |sum re| + |sum im| over the signed taps
    function automatic int lane_score(input int lane);
        logic [`PSS_WIN_LEN-1:0] seq;
        int sre;
        int sim;
        seq = lane_seq(lane);
        sre = 0;
        sim = 0;
        for (int k = 0; k < `PSS_WIN_LEN; k++) begin
            sre += seq[k] ? win_re[k] : -win_re[k];
            sim += seq[k] ? win_im[k] : -win_im[k];
        end
        return (sre < 0 ? -sre : sre) + (sim < 0 ? -sim : sim);
    endfunction

    // --------------------
    // reference model
    // --------------------

    task automatic model_accept(input iq_sample_t s, input pss_mode_e mode,
                                input logic [1:0] req_nid, output logic pulse);
        int score;
        int hits;
        int hit_lane;
        int hit_score;
        pulse = 1'b0;
        if (mode != MODE_PAUSE) begin
            for (int k = `PSS_WIN_LEN - 1; k > 0; k--) begin
                win_re[k] = win_re[k-1];
                win_im[k] = win_im[k-1];
            end
            win_re[0] = int'(s.re);
            win_im[0] = int'(s.im);
            hits      = 0;
            hit_lane  = 0;
            hit_score = 0;
            for (int lane = 0; lane < `PSS_NUM_LANES; lane++) begin
                score = lane_score(lane);
                if (score >= `PSS_THRESHOLD) begin
                    hits++;
                    hit_lane  = lane;
                    hit_score = score;
                end
            end
            if (hits > 0) begin
                lane_hit_seen = 1'b1;
            end
            // FIND only accepts the requested lane
            if (hits == 1 && (mode == MODE_SEARCH || hit_lane == int'(req_nid))) begin
                pulse       = 1'b1;
                model_nid   = 2'(hit_lane);
                model_score = hit_score;
            end
        end
    endtask

    // one four-phase transfer that returns on a falling edge
    task automatic transfer(input iq_sample_t s, input logic exp_pulse);
        int waited;
        @(posedge clk_i);
        sample_i <= s;
        req_i    <= 1'b1;
        waited = 0;
        @(negedge clk_i);
        while (!ack_o) begin
            waited++;
            if (waited > ACK_WAIT) begin
                fail_run("handshake stuck: ack_o never rose after req_i");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
        // ack has to hold until the intake has seen req low
        check_value("ack_o", 32'd1, 32'(ack_o));
        check_value("nid_valid_o (early)", 32'd0, 32'(nid_valid_o));
        // two cycles after ack first read high
        @(negedge clk_i);
        check_value("nid_valid_o", 32'(exp_pulse), 32'(nid_valid_o));
        check_value("nid_o", 32'(model_nid), 32'(nid_o));
        check_value("peak_score_o", 32'(model_score), 32'(peak_score_o));
        waited = 0;
        while (ack_o) begin
            waited++;
            if (waited > ACK_WAIT) begin
                fail_run("handshake stuck: ack_o stayed high after req_i dropped");
            end
            @(negedge clk_i);
        end
    endtask

    task automatic apply_entry(input stim_entry_t e);
        iq_sample_t              s;
        logic                    pulse;
        logic [`PSS_WIN_LEN-1:0] seq;
        int                      amp;
        amp = int'(e.amp);
        @(posedge clk_i);
        mode_i          <= e.mode;
        requested_nid_i <= e.req_nid;
        // enable is registered from the mode
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        lane_hit_seen = 1'b0;
        for (int j = 0; j < int'(e.count); j++) begin
            if (e.kind == KIND_NOISE) begin
                s.re = noise_value(amp);
                s.im = noise_value(amp);
            end else begin
                seq  = lane_seq(int'(e.kind));
                s.re = seq[15 - (j % 16)] ? `PSS_SAMPLE_W'(amp) : `PSS_SAMPLE_W'(-amp);
                s.im = '0;
            end
            model_accept(s, e.mode, e.req_nid, pulse);
            transfer(s, pulse);
        end
        if (e.kind == KIND_NOISE) begin
            check_value("model lane hit on noise", 32'd0, 32'(lane_hit_seen));
        end
        check_value("final nid_o", 32'(e.exp_nid), 32'(nid_o));
        check_value("final peak_score_o", 32'(e.exp_score), 32'(peak_score_o));
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin : stimulus
        void'($urandom(82389));
        reset_ni        <= 1'b0;
        req_i           <= 1'b0;
        sample_i        <= '0;
        mode_i          <= MODE_SEARCH;
        requested_nid_i <= 2'd0;
        for (int k = 0; k < `PSS_WIN_LEN; k++) begin
            win_re[k] = 0;
            win_im[k] = 0;
        end
        model_nid     = 2'd0;
        model_score   = 0;
        lane_hit_seen = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        check_value("ack_o", 32'd0, 32'(ack_o));
        check_value("nid_valid_o", 32'd0, 32'(nid_valid_o));
        check_value("nid_o", 32'd0, 32'(nid_o));
        check_value("peak_score_o", 32'd0, 32'(peak_score_o));
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(STIM_TABLE[i]);
        end
        $display("Regression passed");
        $finish;
    end

    // generous budget per sample plus reset and mode changes
    initial begin : watchdog
        int limit;
        limit = total_samples() * 12 + 200;
        repeat (limit) @(posedge clk_i);
        $display("run timed out after %0d clock cycles", limit);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

/* pss_detector_top.sv */
`timescale 1ns/1ps
`include "pss_macros.svh"

module pss_detector_top (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     req_i,
    input  pss_pkg::iq_sample_t      sample_i,
    output logic                     ack_o,
    input  pss_pkg::pss_mode_e       mode_i,
    input  logic [1:0]               requested_nid_i,
    output logic [1:0]               nid_o,
    output logic                     nid_valid_o,
    output logic [`PSS_SCORE_W-1:0]  peak_score_o
);

    import pss_pkg::*;

    // lane n takes slice n
    localparam logic [`PSS_NUM_LANES*`PSS_WIN_LEN-1:0] LANE_SEQS =
        {`PSS_SEQ_2, `PSS_SEQ_1, `PSS_SEQ_0};

    iq_sample_t   lane_sample;
    logic         lane_stb;
    logic         enable;
    lane_result_t lane_results [`PSS_NUM_LANES];

    // --------------------
    // sample intake
    // --------------------

    pss_sample_intake i_pss_sample_intake (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .req_i        (req_i),
        .sample_i     (sample_i),
        .enable_i     (enable),
        .ack_o        (ack_o),
        .sample_o     (lane_sample),
        .sample_stb_o (lane_stb)
    );

    // --------------------
    // one correlator per N_id_2
    // --------------------

    for (genvar i = 0; i < `PSS_NUM_LANES; i++) begin : g_lane
        pss_correlator_lane #(
            .SEQ (LANE_SEQS[i*`PSS_WIN_LEN +: `PSS_WIN_LEN])
        ) i_pss_correlator_lane (
            .clk_i        (clk_i),
            .reset_ni     (reset_ni),
            .sample_i     (lane_sample),
            .sample_stb_i (lane_stb),
            .result_o     (lane_results[i])
        );
    end

    // --------------------
    // decision
    // --------------------

    pss_decision i_pss_decision (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .mode_i          (mode_i),
        .requested_nid_i (requested_nid_i),
        .results_i       (lane_results),
        .enable_o        (enable),
        .nid_o           (nid_o),
        .nid_valid_o     (nid_valid_o),
        .peak_score_o    (peak_score_o)
    );

endmodule

/* pss_decision.sv */
`timescale 1ns/1ps
`include "pss_macros.svh"

module pss_decision (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  pss_pkg::pss_mode_e       mode_i,
    input  logic [1:0]               requested_nid_i,
    input  pss_pkg::lane_result_t    results_i [`PSS_NUM_LANES],
    output logic                     enable_o,
    output logic [1:0]               nid_o,
    output logic                     nid_valid_o,
    output logic [`PSS_SCORE_W-1:0]  peak_score_o
);

    import pss_pkg::*;

    // enough to count every lane hitting at once
    localparam int CNT_W = $clog2(`PSS_NUM_LANES + 1);

    logic [CNT_W-1:0]        hit_cnt;
    logic [1:0]              hit_nid;
    logic [`PSS_SCORE_W-1:0] hit_score;
    logic                    peak;

    // --------------------
    // hit census
    // --------------------

    // nid and score only matter when exactly one lane hits
    always_comb begin
        hit_cnt   = '0;
        hit_nid   = '0;
        hit_score = '0;
        for (int i = 0; i < `PSS_NUM_LANES; i++) begin
            if (results_i[i].valid && results_i[i].hit) begin
                hit_cnt   = hit_cnt + CNT_W'(1);
                hit_nid   = 2'(i);
                hit_score = results_i[i].score;
            end
        end
    end

    // --------------------
    // mode rules
    // --------------------

    always_comb begin
        case (mode_i)
            MODE_SEARCH: begin
                peak = (hit_cnt == CNT_W'(1));
            end
            MODE_FIND: begin
                // a single hit on some other lane is not a peak
                peak = (hit_cnt == CNT_W'(1)) && (hit_nid == requested_nid_i);
            end
            default: begin
                // paused, or an unused mode code
                peak = 1'b0;
            end
        endcase
    end

    // --------------------
    // output registers
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            enable_o     <= 1'b0;
            nid_valid_o  <= 1'b0;
            nid_o        <= '0;
            peak_score_o <= '0;
        end else begin
            // lanes stop taking samples while paused
            enable_o    <= (mode_i != MODE_PAUSE);
            nid_valid_o <= peak;
            // hold the last peak until a new one arrives
            if (peak) begin
                nid_o        <= hit_nid;
                peak_score_o <= hit_score;
            end
        end
    end

endmodule

/* pss_correlator_lane.sv */
`timescale 1ns/1ps
`include "pss_macros.svh"

module pss_correlator_lane #(
    parameter logic [`PSS_WIN_LEN-1:0] SEQ = `PSS_SEQ_0
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  pss_pkg::iq_sample_t   sample_i,
    input  logic                  sample_stb_i,
    output pss_pkg::lane_result_t result_o
);

    import pss_pkg::*;

    // signed accumulator, wide enough for 16 full-scale samples
    localparam int ACC_W = `PSS_SAMPLE_W + $clog2(`PSS_WIN_LEN) + 1;

    // 15 past samples, the new one makes up the 16th tap
    iq_sample_t hist_q [`PSS_WIN_LEN-1];
    iq_sample_t taps   [`PSS_WIN_LEN];

    logic signed [ACC_W-1:0]        sum_re;
    logic signed [ACC_W-1:0]        sum_im;
    logic        [ACC_W-1:0]        abs_re;
    logic        [ACC_W-1:0]        abs_im;
    logic        [`PSS_SCORE_W-1:0] score;

    // --------------------
    // window as seen after the shift
    // --------------------

    always_comb begin
        taps[0] = sample_i;
        for (int k = 1; k < `PSS_WIN_LEN; k++) begin
            taps[k] = hist_q[k-1];
        end
    end

    // --------------------
    // signed sums and magnitude
    // --------------------

    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int k = 0; k < `PSS_WIN_LEN; k++) begin
            // +1 tap adds, -1 tap subtracts
            if (SEQ[k]) begin
                sum_re = sum_re + ACC_W'(taps[k].re);
                sum_im = sum_im + ACC_W'(taps[k].im);
            end else begin
                sum_re = sum_re - ACC_W'(taps[k].re);
                sum_im = sum_im - ACC_W'(taps[k].im);
            end
        end
    end

    // |re| + |im| instead of the true modulus
    assign abs_re = sum_re[ACC_W-1] ? ACC_W'(-sum_re) : ACC_W'(sum_re);
    assign abs_im = sum_im[ACC_W-1] ? ACC_W'(-sum_im) : ACC_W'(sum_im);
    assign score  = `PSS_SCORE_W'(abs_re) + `PSS_SCORE_W'(abs_im);

    // --------------------
    // window shift and result register
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < `PSS_WIN_LEN - 1; k++) begin
                hist_q[k] <= '0;
            end
            result_o <= '0;
        end else begin
            result_o.valid <= sample_stb_i;
            if (sample_stb_i) begin
                // oldest sample falls off the end
                for (int k = 0; k < `PSS_WIN_LEN - 1; k++) begin
                    hist_q[k] <= taps[k];
                end
                result_o.score <= score;
                result_o.hit   <= (score >= `PSS_SCORE_W'(`PSS_THRESHOLD));
            end
        end
    end

endmodule

/* pss_sample_intake.sv */
`timescale 1ns/1ps

module pss_sample_intake (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic                req_i,
    input  pss_pkg::iq_sample_t sample_i,
    input  logic                enable_i,
    output logic                ack_o,
    output pss_pkg::iq_sample_t sample_o,
    output logic                sample_stb_o
);

    // --------------------
    // handshake state
    // --------------------

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } intake_state_e;

    intake_state_e state_q;

    // ack is just the state, so it rises and falls on the edge that sees req change
    assign ack_o = (state_q == ST_ACK);

    // --------------------
    // four-phase receiver
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= ST_IDLE;
            sample_stb_o <= 1'b0;
        end else begin
            // strobe lives for the first ack cycle only
            sample_stb_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= ST_ACK;
                        // paused: still acknowledge, but drop the sample
                        sample_stb_o <= enable_i;
                    end
                end
                ST_ACK: begin
                    // wait for the source to release req
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // sample register, loaded when a new request is seen
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_i) begin
            sample_o <= sample_i;
        end
    end

endmodule

/* pss_pkg.sv */
`include "pss_macros.svh"

package pss_pkg;

    // --------------------
    // sample stream
    // --------------------

    // one complex baseband sample
    typedef struct packed {
        logic signed [`PSS_SAMPLE_W-1:0] re;
        logic signed [`PSS_SAMPLE_W-1:0] im;
    } iq_sample_t;

    // --------------------
    // lane output
    // --------------------

    // valid pulses for one cycle per accepted sample
    // hit and score hold until the next sample
    typedef struct packed {
        logic                    valid;
        logic                    hit;
        logic [`PSS_SCORE_W-1:0] score;
    } lane_result_t;

    // --------------------
    // detector mode
    // --------------------

    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } pss_mode_e;

endpackage

/* pss_macros.svh */
`ifndef PSS_MACROS_SVH
`define PSS_MACROS_SVH

// --------------------
// datapath sizing
// --------------------

// width of each I and Q component, signed
`define PSS_SAMPLE_W   8
// correlation window, in samples
`define PSS_WIN_LEN    16
// one lane per N_id_2 hypothesis
`define PSS_NUM_LANES  3
// |sum re| + |sum im| tops out at 2 * 16 * 128
`define PSS_SCORE_W    13
// minimum score for a hit
`define PSS_THRESHOLD  1200

// --------------------
// local sign sequences
// --------------------

// bit set means tap +1, bit 0 is the newest sample
// scrambled walsh rows, zero cross-correlation at zero lag
`define PSS_SEQ_0      16'hB271
`define PSS_SEQ_1      16'h4D71
`define PSS_SEQ_2      16'h4281

`endif
